// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build fabric_tb with Verilator, run it and check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module fabric_tb -Mdir obj_dir -f flist.f
	./obj_dir/Vfabric_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Result: failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "Result: run ended early"; exit 1; fi
	@echo "Result: passed"

clean:
	rm -rf obj_dir $(LOG)

// File: bench/clock_gen.sv
module clock_gen (
    output logic core_clock,
    output logic core_reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        core_clock = 1'b0;
        forever #5 core_clock = ~core_clock;
    end

    // Reset spans eight rising edges, released just after the last
    initial begin
        core_reset = 1'b1;
        repeat (8) @(posedge core_clock);
        #1 core_reset = 1'b0;
    end

endmodule

// File: bench/fabric_properties.sv
module fabric_properties (
    input logic                 core_clock,
    input logic                 core_reset,
    input fabric_pkg::apb_req_t host_req_i,
    input fabric_pkg::apb_rsp_t host_rsp_i,
    input fabric_pkg::apb_req_t core_req_i,
    input fabric_pkg::apb_rsp_t core_rsp_i,
    input fabric_pkg::apb_req_t bus_req_i,
    input fabric_pkg::apb_rsp_t bus_rsp_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    // Waiting requests hold until pready
    assert property (@(posedge core_clock) disable iff (core_reset)
        host_req_i.psel && host_req_i.penable && !host_rsp_i.pready |=> $stable(host_req_i))
        else begin
            $error("host request changed while waiting for pready");
            failures++;
        end
    assert property (@(posedge core_clock) disable iff (core_reset)
        core_req_i.psel && core_req_i.penable && !core_rsp_i.pready |=> $stable(core_req_i))
        else begin
            $error("core request changed while waiting for pready");
            failures++;
        end
    assert property (@(posedge core_clock) disable iff (core_reset)
        bus_req_i.psel && bus_req_i.penable && !bus_rsp_i.pready |=> $stable(bus_req_i))
        else begin
            $error("shared bus request changed while waiting for pready");
            failures++;
        end

    // Access phase only after a setup cycle
    assert property (@(posedge core_clock) disable iff (core_reset)
        $rose(bus_req_i.penable) |-> $past(bus_req_i.psel) && bus_req_i.psel)
        else begin
            $error("shared bus penable rose without a setup cycle");
            failures++;
        end

    // pready reaches only the requester whose request is on the shared bus
    assert property (@(posedge core_clock) disable iff (core_reset)
        host_rsp_i.pready |-> bus_req_i == host_req_i)
        else begin
            $error("host saw pready while its request was not on the shared bus");
            failures++;
        end
    assert property (@(posedge core_clock) disable iff (core_reset)
        core_rsp_i.pready |-> bus_req_i == core_req_i)
        else begin
            $error("core saw pready while its request was not on the shared bus");
            failures++;
        end

endmodule

// File: bench/fabric_tb.sv
module fabric_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                          core_clock;
    logic                          core_reset;
    logic                          embed_mode;
    fabric_pkg::apb_req_t          host_req;
    fabric_pkg::apb_rsp_t          host_rsp;
    fabric_pkg::apb_req_t          core_req;
    fabric_pkg::apb_rsp_t          core_rsp;
    logic [fabric_pkg::GPIO_N-1:0] gpio_in;
    logic [fabric_pkg::GPIO_N-1:0] gpio_out;
    logic [fabric_pkg::GPIO_N-1:0] gpio_oe;
    logic                          ext_irq;
    logic                          irq;
    logic                          tick;
    int                            errors;
    int                            checks;

    clock_gen u_clock (
        .core_clock (core_clock),
        .core_reset (core_reset)
    );

    bus_fabric_top dut (
        .core_clock   (core_clock),
        .core_reset   (core_reset),
        .embed_mode_i (embed_mode),
        .host_req_i   (host_req),
        .host_rsp_o   (host_rsp),
        .core_req_i   (core_req),
        .core_rsp_o   (core_rsp),
        .gpio_in_i    (gpio_in),
        .gpio_out_o   (gpio_out),
        .gpio_oe_o    (gpio_oe),
        .ext_irq_i    (ext_irq),
        .irq_o        (irq),
        .tick_o       (tick)
    );

    bind bus_fabric_top fabric_properties u_props (
        .core_clock (core_clock),
        .core_reset (core_reset),
        .host_req_i (host_req_i),
        .host_rsp_i (host_rsp_o),
        .core_req_i (core_req_i),
        .core_rsp_i (core_rsp_o),
        .bus_req_i  (bus_req),
        .bus_rsp_i  (bus_rsp)
    );

    function automatic fabric_pkg::apb_rsp_t expect_rsp(
        input logic [fabric_pkg::DATA_W-1:0] data, input bit err);
        expect_rsp.prdata  = data;
        expect_rsp.pready  = 1'b1;
        expect_rsp.pslverr = err;
    endfunction

    task automatic check_rsp(input fabric_pkg::apb_rsp_t got, input fabric_pkg::apb_rsp_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s response %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input logic [fabric_pkg::DATA_W-1:0] got,
                              input logic [fabric_pkg::DATA_W-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0d ns: %s took %0d cycles, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic drive_port(input bit use_core, input fabric_pkg::apb_req_t req);
        if (use_core) begin
            core_req = req;
        end else begin
            host_req = req;
        end
    endtask

    // Starts and ends 1 ns after a rising edge, counts setup through completion
    task automatic run_transfer(input bit use_core, input logic wr,
                                input logic [fabric_pkg::ADDR_W-1:0] addr,
                                input logic [fabric_pkg::DATA_W-1:0] wdata,
                                output fabric_pkg::apb_rsp_t rsp, output int cycles);
        fabric_pkg::apb_req_t req;
        fabric_pkg::apb_rsp_t seen;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = wr;
        req.paddr   = addr;
        req.pwdata  = wdata;
        cycles      = 1;
        drive_port(use_core, req);
        @(posedge core_clock);
        #1;
        req.penable = 1'b1;
        drive_port(use_core, req);
        do begin
            @(negedge core_clock);
            cycles++;
            seen = use_core ? core_rsp : host_rsp;
            @(posedge core_clock);
            #1;
        end while (!seen.pready);
        rsp = seen;
        drive_port(use_core, '0);
    endtask

    task automatic apb_write(input bit use_core, input logic [fabric_pkg::ADDR_W-1:0] addr,
                             input logic [fabric_pkg::DATA_W-1:0] data,
                             output fabric_pkg::apb_rsp_t rsp, output int cycles);
        run_transfer(use_core, 1'b1, addr, data, rsp, cycles);
        // No read data on a write
        rsp.prdata = '0;
    endtask

    task automatic apb_read(input bit use_core, input logic [fabric_pkg::ADDR_W-1:0] addr,
                            output fabric_pkg::apb_rsp_t rsp, output int cycles);
        run_transfer(use_core, 1'b0, addr, '0, rsp, cycles);
    endtask

    task automatic write_expect(input bit use_core, input logic [fabric_pkg::ADDR_W-1:0] addr,
                                input logic [fabric_pkg::DATA_W-1:0] data, input bit err,
                                input int n, input string what);
        fabric_pkg::apb_rsp_t rsp;
        int cycles;
        apb_write(use_core, addr, data, rsp, cycles);
        check_rsp(rsp, expect_rsp('0, err), what);
        check_cycles(cycles, n, what);
    endtask

    task automatic read_expect(input bit use_core, input logic [fabric_pkg::ADDR_W-1:0] addr,
                               input logic [fabric_pkg::DATA_W-1:0] data, input bit err,
                               input int n, input string what);
        fabric_pkg::apb_rsp_t rsp;
        int cycles;
        apb_read(use_core, addr, rsp, cycles);
        check_rsp(rsp, expect_rsp(data, err), what);
        check_cycles(cycles, n, what);
    endtask

    task automatic test_reset_state();
        repeat (4) @(negedge core_clock);
        check_data(16'({host_rsp.pready, host_rsp.pslverr, core_rsp.pready, core_rsp.pslverr,
                        tick}), '0, "status flags in reset");
        check_data({gpio_oe, gpio_out}, '0, "gpio outputs in reset");
        wait (!core_reset);
        // Divider value zero ticks every cycle
        repeat (3) begin
            @(posedge core_clock);
            @(negedge core_clock);
            check_data(16'(tick), 16'h1, "tick_o after reset");
        end
        @(posedge core_clock);
        #1;
    endtask

    task automatic test_ram();
        logic [fabric_pkg::ADDR_W-1:0] addrs [8];
        logic [fabric_pkg::DATA_W-1:0] words [8];
        for (int i = 0; i < 8; i++) begin
            addrs[i] = fabric_pkg::RAM_BASE_NORMAL + 16'(i * 64) + 16'($urandom % 64);
            words[i] = 16'($urandom);
            write_expect(1'(i % 2), addrs[i], words[i], 1'b0, 3, "ram write");
        end
        for (int i = 0; i < 8; i++) begin
            read_expect(1'(i % 3 == 0), addrs[i], words[i], 1'b0, 3, "ram read");
        end
    endtask

    task automatic test_embed();
        logic [fabric_pkg::DATA_W-1:0] data;
        data       = 16'($urandom);
        embed_mode = 1'b1;
        write_expect(1'b0, fabric_pkg::RAM_BASE_EMBED + 16'h0005, data, 1'b0, 3, "embed write");
        read_expect(1'b1, fabric_pkg::RAM_BASE_EMBED + 16'h0005, data, 1'b0, 3, "embed read");
        read_expect(1'b0, fabric_pkg::RAM_BASE_NORMAL + 16'h0005, '0, 1'b1, 2,
                    "normal window in embed mode");
        // Both windows share one storage
        embed_mode = 1'b0;
        read_expect(1'b0, fabric_pkg::RAM_BASE_NORMAL + 16'h0005, data, 1'b0, 3, "normal read");
    endtask

    task automatic test_gpio();
        logic [fabric_pkg::GPIO_N-1:0] out_val;
        logic [fabric_pkg::GPIO_N-1:0] dir_val;
        logic [fabric_pkg::GPIO_N-1:0] pins;
        out_val = 8'($urandom);
        dir_val = 8'($urandom);
        // Nonzero so the new pins differ from the idle ones
        pins    = 8'($urandom) | 8'h01;
        write_expect(1'b0, fabric_pkg::GPIO_OUT_ADDR, {8'($urandom), out_val}, 1'b0, 2, "out write");
        check_data(16'(gpio_out), 16'(out_val), "gpio_out_o");
        write_expect(1'b1, fabric_pkg::GPIO_DIR_ADDR, 16'(dir_val), 1'b0, 2, "dir write");
        check_data(16'(gpio_oe), 16'(dir_val), "gpio_oe_o");
        read_expect(1'b0, fabric_pkg::GPIO_OUT_ADDR, 16'(out_val), 1'b0, 2, "out read");
        read_expect(1'b1, fabric_pkg::GPIO_DIR_ADDR, 16'(dir_val), 1'b0, 2, "dir read");
        gpio_in = pins;
        // Access cycle comes one edge after the change, still the old pins
        read_expect(1'b0, fabric_pkg::GPIO_IN_ADDR, 16'h0000, 1'b0, 2, "input read before sync");
        read_expect(1'b0, fabric_pkg::GPIO_IN_ADDR, 16'(pins), 1'b0, 2, "input read");
        write_expect(1'b0, fabric_pkg::GPIO_IN_ADDR, 16'hFFFF, 1'b1, 2, "input write");
        check_data(16'(gpio_out), 16'(out_val), "gpio_out_o after rejected write");
        ext_irq = 1'b1;
        @(posedge core_clock);
        @(negedge core_clock);
        check_data(16'(irq), 16'h0, "irq_o one cycle after ext_irq_i");
        @(posedge core_clock);
        @(negedge core_clock);
        check_data(16'(irq), 16'h1, "irq_o two cycles after ext_irq_i");
        @(posedge core_clock);
        #1;
        ext_irq = 1'b0;
    endtask

    task automatic test_divider(input logic [fabric_pkg::DIV_W-1:0] d);
        int last;
        int seen;
        last = -1;
        seen = 0;
        write_expect(1'b0, fabric_pkg::CLKDIV_ADDR, 16'(d), 1'b0, 2, "divider write");
        for (int n = 0; n < 64 && seen < 3; n++) begin
            @(negedge core_clock);
            if (tick) begin
                if (last >= 0) begin
                    check_cycles(n - last, int'(d) + 1, "tick_o spacing");
                end
                last = n;
                seen++;
            end
        end
        if (seen < 3) begin
            errors++;
            $display("Divider value %0d gave only %0d ticks in 64 cycles", d, seen);
        end
        @(posedge core_clock);
        #1;
        read_expect(1'b1, fabric_pkg::CLKDIV_ADDR, 16'(d), 1'b0, 2, "divider readback");
    endtask

    task automatic test_arbitration();
        fabric_pkg::apb_rsp_t          host_r;
        fabric_pkg::apb_rsp_t          core_r;
        int                            host_n;
        int                            core_n;
        logic [fabric_pkg::DATA_W-1:0] host_w;
        logic [fabric_pkg::DATA_W-1:0] core_w;
        host_w = 16'($urandom);
        core_w = 16'($urandom);
        fork
            apb_write(1'b0, fabric_pkg::RAM_BASE_NORMAL + 16'h0100, host_w, host_r, host_n);
            apb_write(1'b1, fabric_pkg::RAM_BASE_NORMAL + 16'h0101, core_w, core_r, core_n);
        join
        check_rsp(host_r, expect_rsp('0, 1'b0), "host write under contention");
        check_rsp(core_r, expect_rsp('0, 1'b0), "core write under contention");
        // Core sits out the host transfer, then runs its own
        check_cycles(host_n, 3, "host write under contention");
        check_cycles(core_n, 6, "core write under contention");
        fork
            apb_read(1'b0, fabric_pkg::RAM_BASE_NORMAL + 16'h0101, host_r, host_n);
            apb_read(1'b1, fabric_pkg::RAM_BASE_NORMAL + 16'h0100, core_r, core_n);
        join
        check_rsp(host_r, expect_rsp(core_w, 1'b0), "host read under contention");
        check_rsp(core_r, expect_rsp(host_w, 1'b0), "core read under contention");
        check_cycles(host_n, 3, "host read under contention");
        check_cycles(core_n, 6, "core read under contention");
    endtask

    task automatic test_unmapped();
        logic [fabric_pkg::ADDR_W-1:0] holes [7];
        fabric_pkg::apb_rsp_t          rsp;
        int                            cycles;
        holes = '{fabric_pkg::CLKDIV_ADDR + 16'h1, 16'h1000, 16'h1013, 16'h0000,
                  16'h7DFF, 16'h8000, 16'hFFFF};
        foreach (holes[i]) begin
            read_expect(1'(i % 2), holes[i], '0, 1'b1, 2, "unmapped read");
        end
        // Unmapped write returns zero data as well
        run_transfer(1'b0, 1'b1, 16'h1002, 16'h1234, rsp, cycles);
        check_rsp(rsp, expect_rsp('0, 1'b1), "unmapped write");
        check_cycles(cycles, 2, "unmapped write");
    endtask

    // About 45 transfers, margin covers reset and the tick waits
    initial begin : watchdog
        int limit_cycles;
        limit_cycles = 45 * 20 + 300;
        repeat (limit_cycles) @(posedge core_clock);
        $display("Timeout: tests did not finish within %0d cycles", limit_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        embed_mode = 1'b0;
        host_req   = '0;
        core_req   = '0;
        gpio_in    = '0;
        ext_irq    = 1'b0;
        errors     = 0;
        checks     = 0;
        void'($urandom(32'h815cfec2));
        test_reset_state();
        test_ram();
        test_embed();
        test_gpio();
        test_divider(4'd3);
        test_divider(4'd0);
        test_divider(4'($urandom));
        test_arbitration();
        test_unmapped();
        // Protocol assertion failures count as errors
        errors += dut.u_props.failures;
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
verilog/fabric_pkg.sv
verilog/bus_arbiter.sv
verilog/addr_decoder.sv
verilog/scratch_ram.sv
verilog/gpio_port.sv
verilog/clock_divider.sv
verilog/bus_fabric_top.sv
bench/clock_gen.sv
bench/fabric_properties.sv
bench/fabric_tb.sv

// File: verilog/addr_decoder.sv
module addr_decoder (
    input  logic                 core_clock,
    input  logic                 core_reset,
    input  logic                 embed_mode_i,
    input  fabric_pkg::apb_req_t bus_req_i,
    output fabric_pkg::apb_rsp_t bus_rsp_o,
    output fabric_pkg::apb_req_t ram_req_o,
    input  fabric_pkg::apb_rsp_t ram_rsp_i,
    output fabric_pkg::apb_req_t gpio_req_o,
    input  fabric_pkg::apb_rsp_t gpio_rsp_i,
    output fabric_pkg::apb_req_t div_req_o,
    input  fabric_pkg::apb_rsp_t div_rsp_i
);

    logic [fabric_pkg::ADDR_W-1:0] ram_base;
    logic [fabric_pkg::ADDR_W-1:0] addr;
    logic                          in_ram;
    fabric_pkg::target_e           tgt_d;
    fabric_pkg::target_e           tgt_q;
    fabric_pkg::target_e           tgt;

    assign addr     = bus_req_i.paddr;
    assign ram_base = embed_mode_i ? fabric_pkg::RAM_BASE_EMBED : fabric_pkg::RAM_BASE_NORMAL;

    // Window is size aligned, so only the upper bits are compared
    assign in_ram = addr[fabric_pkg::ADDR_W-1:fabric_pkg::RAM_AW]
                    == ram_base[fabric_pkg::ADDR_W-1:fabric_pkg::RAM_AW];

    always_comb begin
        if (in_ram) begin
            tgt_d = fabric_pkg::TGT_RAM;
        end else if (addr == fabric_pkg::CLKDIV_ADDR) begin
            tgt_d = fabric_pkg::TGT_CLKDIV;
        end else if (addr == fabric_pkg::GPIO_OUT_ADDR || addr == fabric_pkg::GPIO_DIR_ADDR
                     || addr == fabric_pkg::GPIO_IN_ADDR) begin
            tgt_d = fabric_pkg::TGT_GPIO;
        end else begin
            tgt_d = fabric_pkg::TGT_NONE;
        end
    end

    // Target captured at setup holds through the access phase
    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            tgt_q <= fabric_pkg::TGT_NONE;
        end else if (bus_req_i.psel && !bus_req_i.penable) begin
            tgt_q <= tgt_d;
        end
    end

    assign tgt = bus_req_i.penable ? tgt_q : tgt_d;

    always_comb begin
        ram_req_o       = bus_req_i;
        gpio_req_o      = bus_req_i;
        div_req_o       = bus_req_i;
        ram_req_o.psel  = bus_req_i.psel && (tgt == fabric_pkg::TGT_RAM);
        gpio_req_o.psel = bus_req_i.psel && (tgt == fabric_pkg::TGT_GPIO);
        div_req_o.psel  = bus_req_i.psel && (tgt == fabric_pkg::TGT_CLKDIV);
    end

    always_comb begin
        bus_rsp_o = '0;
        if (bus_req_i.psel) begin
            case (tgt)
                fabric_pkg::TGT_RAM:    bus_rsp_o = ram_rsp_i;
                fabric_pkg::TGT_GPIO:   bus_rsp_o = gpio_rsp_i;
                fabric_pkg::TGT_CLKDIV: bus_rsp_o = div_rsp_i;
                default: begin
                    // Unclaimed address ends in its first access cycle
                    bus_rsp_o.pready  = bus_req_i.penable;
                    bus_rsp_o.pslverr = bus_req_i.penable;
                end
            endcase
        end
    end

endmodule

// File: verilog/bus_arbiter.sv
module bus_arbiter (
    input  logic                 core_clock,
    input  logic                 core_reset,
    input  fabric_pkg::apb_req_t host_req_i,
    output fabric_pkg::apb_rsp_t host_rsp_o,
    input  fabric_pkg::apb_req_t core_req_i,
    output fabric_pkg::apb_rsp_t core_rsp_o,
    output fabric_pkg::apb_req_t bus_req_o,
    input  fabric_pkg::apb_rsp_t bus_rsp_i
);

    logic busy_q;
    logic owner_q;
    logic grant_core;
    logic complete;
    fabric_pkg::apb_req_t sel_req;

    // Owner 0 is the host, 1 is the core
    always_comb begin
        if (busy_q) begin
            grant_core = owner_q;
        end else begin
            grant_core = !host_req_i.psel && core_req_i.psel;
        end
    end

    assign sel_req = grant_core ? core_req_i : host_req_i;

    // First granted cycle is always a setup cycle on the shared bus,
    // even for a requester that has been waiting in its access phase
    always_comb begin
        bus_req_o         = sel_req;
        bus_req_o.penable = sel_req.penable && busy_q;
    end

    assign complete = bus_req_o.psel && bus_req_o.penable && bus_rsp_i.pready;

    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
        end else if (complete) begin
            busy_q <= 1'b0;
        end else if (bus_req_o.psel) begin
            busy_q  <= 1'b1;
            owner_q <= grant_core;
        end
    end

    // Response goes only to the owner, the other side sees no pready
    always_comb begin
        host_rsp_o = '0;
        core_rsp_o = '0;
        if (grant_core) begin
            core_rsp_o = bus_rsp_i;
        end else begin
            host_rsp_o = bus_rsp_i;
        end
    end

endmodule

// File: verilog/bus_fabric_top.sv
module bus_fabric_top (
    input  logic                         core_clock,
    input  logic                         core_reset,
    input  logic                         embed_mode_i,
    input  fabric_pkg::apb_req_t         host_req_i,
    output fabric_pkg::apb_rsp_t         host_rsp_o,
    input  fabric_pkg::apb_req_t         core_req_i,
    output fabric_pkg::apb_rsp_t         core_rsp_o,
    input  logic [fabric_pkg::GPIO_N-1:0] gpio_in_i,
    output logic [fabric_pkg::GPIO_N-1:0] gpio_out_o,
    output logic [fabric_pkg::GPIO_N-1:0] gpio_oe_o,
    input  logic                         ext_irq_i,
    output logic                         irq_o,
    output logic                         tick_o
);

    fabric_pkg::apb_req_t bus_req;
    fabric_pkg::apb_rsp_t bus_rsp;
    fabric_pkg::apb_req_t ram_req;
    fabric_pkg::apb_rsp_t ram_rsp;
    fabric_pkg::apb_req_t gpio_req;
    fabric_pkg::apb_rsp_t gpio_rsp;
    fabric_pkg::apb_req_t div_req;
    fabric_pkg::apb_rsp_t div_rsp;

    bus_arbiter u_arbiter (
        .core_clock (core_clock),
        .core_reset (core_reset),
        .host_req_i (host_req_i),
        .host_rsp_o (host_rsp_o),
        .core_req_i (core_req_i),
        .core_rsp_o (core_rsp_o),
        .bus_req_o  (bus_req),
        .bus_rsp_i  (bus_rsp)
    );

    addr_decoder u_decoder (
        .core_clock   (core_clock),
        .core_reset   (core_reset),
        .embed_mode_i (embed_mode_i),
        .bus_req_i    (bus_req),
        .bus_rsp_o    (bus_rsp),
        .ram_req_o    (ram_req),
        .ram_rsp_i    (ram_rsp),
        .gpio_req_o   (gpio_req),
        .gpio_rsp_i   (gpio_rsp),
        .div_req_o    (div_req),
        .div_rsp_i    (div_rsp)
    );

    scratch_ram u_ram (
        .core_clock (core_clock),
        .core_reset (core_reset),
        .req_i      (ram_req),
        .rsp_o      (ram_rsp)
    );

    gpio_port u_gpio (
        .core_clock (core_clock),
        .core_reset (core_reset),
        .req_i      (gpio_req),
        .rsp_o      (gpio_rsp),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oe_o  (gpio_oe_o),
        .ext_irq_i  (ext_irq_i),
        .irq_o      (irq_o)
    );

    clock_divider u_divider (
        .core_clock (core_clock),
        .core_reset (core_reset),
        .req_i      (div_req),
        .rsp_o      (div_rsp),
        .tick_o     (tick_o)
    );

endmodule

// File: verilog/clock_divider.sv
module clock_divider (
    input  logic                 core_clock,
    input  logic                 core_reset,
    input  fabric_pkg::apb_req_t req_i,
    output fabric_pkg::apb_rsp_t rsp_o,
    output logic                 tick_o
);

    logic                         access;
    logic                         write;
    logic [fabric_pkg::DIV_W-1:0] div_q;
    logic [fabric_pkg::DIV_W-1:0] cnt_q;
    logic                         tick_q;

    assign access = req_i.psel && req_i.penable;
    assign write  = access && req_i.pwrite;

    // Down counter, one tick per d+1 cycles
    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            div_q  <= '0;
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end else if (write) begin
            div_q  <= req_i.pwdata[fabric_pkg::DIV_W-1:0];
            cnt_q  <= req_i.pwdata[fabric_pkg::DIV_W-1:0];
            tick_q <= 1'b0;
        end else if (cnt_q == '0) begin
            cnt_q  <= div_q;
            tick_q <= 1'b1;
        end else begin
            cnt_q  <= cnt_q - 1'b1;
            tick_q <= 1'b0;
        end
    end

    assign rsp_o.prdata  = {{(fabric_pkg::DATA_W - fabric_pkg::DIV_W){1'b0}}, div_q};
    assign rsp_o.pready  = access;
    assign rsp_o.pslverr = 1'b0;

    assign tick_o = tick_q;

endmodule

// File: verilog/fabric_pkg.sv
package fabric_pkg;

    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;

    // Scratch RAM geometry
    localparam int RAM_WORDS = 512;
    localparam int RAM_AW    = 9;

    // RAM window bases, both aligned to the window size
    localparam logic [ADDR_W-1:0] RAM_BASE_NORMAL = 16'h7E00;
    localparam logic [ADDR_W-1:0] RAM_BASE_EMBED  = 16'h0000;

    // Register map
    localparam logic [ADDR_W-1:0] CLKDIV_ADDR   = 16'h1001;
    localparam logic [ADDR_W-1:0] GPIO_OUT_ADDR = 16'h1010;
    localparam logic [ADDR_W-1:0] GPIO_DIR_ADDR = 16'h1011;
    localparam logic [ADDR_W-1:0] GPIO_IN_ADDR  = 16'h1012;

    // Peripheral sizes
    localparam int GPIO_N = 8;
    localparam int DIV_W  = 4;

    // APB request, requester to target
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    // APB response, target to requester
    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // Decoded target of a transfer
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_RAM,
        TGT_GPIO,
        TGT_CLKDIV
    } target_e;

endpackage

// File: verilog/gpio_port.sv
module gpio_port (
    input  logic                         core_clock,
    input  logic                         core_reset,
    input  fabric_pkg::apb_req_t         req_i,
    output fabric_pkg::apb_rsp_t         rsp_o,
    input  logic [fabric_pkg::GPIO_N-1:0] gpio_in_i,
    output logic [fabric_pkg::GPIO_N-1:0] gpio_out_o,
    output logic [fabric_pkg::GPIO_N-1:0] gpio_oe_o,
    input  logic                         ext_irq_i,
    output logic                         irq_o
);

    logic                          access;
    logic                          wr_err;
    logic [1:0]                    reg_sel;
    logic [fabric_pkg::GPIO_N-1:0] out_q;
    logic [fabric_pkg::GPIO_N-1:0] dir_q;
    logic [fabric_pkg::GPIO_N-1:0] in_meta_q;
    logic [fabric_pkg::GPIO_N-1:0] in_sync_q;
    logic [1:0]                    irq_sync_q;
    logic [fabric_pkg::GPIO_N-1:0] rdata;

    assign access  = req_i.psel && req_i.penable;
    assign reg_sel = req_i.paddr[1:0];
    // Input register is read only
    assign wr_err  = access && req_i.pwrite && (reg_sel == fabric_pkg::GPIO_IN_ADDR[1:0]);

    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            out_q <= '0;
            dir_q <= '0;
        end else if (access && req_i.pwrite) begin
            if (reg_sel == fabric_pkg::GPIO_OUT_ADDR[1:0]) begin
                out_q <= req_i.pwdata[fabric_pkg::GPIO_N-1:0];
            end
            if (reg_sel == fabric_pkg::GPIO_DIR_ADDR[1:0]) begin
                dir_q <= req_i.pwdata[fabric_pkg::GPIO_N-1:0];
            end
        end
    end

    // Two-flop synchronizers for pins and interrupt
    always_ff @(posedge core_clock) begin
        in_meta_q  <= gpio_in_i;
        in_sync_q  <= in_meta_q;
        irq_sync_q <= {irq_sync_q[0], ext_irq_i};
    end

    always_comb begin
        case (reg_sel)
            fabric_pkg::GPIO_OUT_ADDR[1:0]: rdata = out_q;
            fabric_pkg::GPIO_DIR_ADDR[1:0]: rdata = dir_q;
            fabric_pkg::GPIO_IN_ADDR[1:0]:  rdata = in_sync_q;
            default:                        rdata = '0;
        endcase
    end

    assign rsp_o.prdata  = {{(fabric_pkg::DATA_W - fabric_pkg::GPIO_N){1'b0}}, rdata};
    assign rsp_o.pready  = access;
    assign rsp_o.pslverr = wr_err;

    assign gpio_out_o = out_q;
    assign gpio_oe_o  = dir_q;
    assign irq_o      = irq_sync_q[1];

endmodule

// File: verilog/scratch_ram.sv
module scratch_ram (
    input  logic                 core_clock,
    input  logic                 core_reset,
    input  fabric_pkg::apb_req_t req_i,
    output fabric_pkg::apb_rsp_t rsp_o
);

    logic                          access;
    logic                          wait_q;
    logic [fabric_pkg::RAM_AW-1:0] addr;
    logic [fabric_pkg::DATA_W-1:0] rdata_q;
    logic [fabric_pkg::DATA_W-1:0] mem [fabric_pkg::RAM_WORDS];

    assign access = req_i.psel && req_i.penable;
    assign addr   = req_i.paddr[fabric_pkg::RAM_AW-1:0];

    // Wait state covers the first access cycle
    always_ff @(posedge core_clock) begin
        if (core_reset) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= access && !wait_q;
        end
    end

    always_ff @(posedge core_clock) begin
        if (access && !wait_q) begin
            rdata_q <= mem[addr];
        end
        if (access && wait_q && req_i.pwrite) begin
            mem[addr] <= req_i.pwdata;
        end
    end

    assign rsp_o.prdata  = rdata_q;
    assign rsp_o.pready  = wait_q;
    assign rsp_o.pslverr = 1'b0;

endmodule
